//--- all.f
src/divmmc_pkg.sv
src/divmmc_automap.sv
src/divmmc_mem_map.sv
src/divmmc_spi.sv
src/divmmc_sd_port.sv
src/divmmc.sv
tests/divmmc_asserts.sv
tests/divmmc_tb.sv

//--- Bender.yml
package:
  name: divmmc

sources:
  - src/divmmc_pkg.sv
  - src/divmmc_automap.sv
  - src/divmmc_mem_map.sv
  - src/divmmc_spi.sv
  - src/divmmc_sd_port.sv
  - src/divmmc.sv
  - target: test
    files:
      - tests/divmmc_asserts.sv
      - tests/divmmc_tb.sv

//--- tests/divmmc_tb.sv
module divmmc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int cycle_limit = 3000;  // Whole run is a few hundred cycles

   logic                  clk;
   logic                  rst_n;
   divmmc_pkg::z80_bus_t  bus;
   logic [7:0]            d_in;
   logic [7:0]            d_out;
   logic                  d_oe;
   logic                  program_n;
   logic                  nmi_button_n;
   logic                  nmi_to_cpu_n;
   logic                  zxromcs;
   divmmc_pkg::mem_sel_t  mem;
   logic                  miso;
   divmmc_pkg::spi_pins_t sd;

   int         errors = 0;
   int         cycles = 0;
   logic [7:0] slave_shift = 8'hFF;  // SD card model, MSB on miso
   logic       prev_sck = 1'b0;
   logic [7:0] mosi_seen = 8'h00;    // Bits seen by the card
   int         sck_pulses = 0;

   divmmc divmmc_inst (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("Run stopped, no end after %0d cycles", cycles);
         $display("tests failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // SD card model, next bit after each falling sck
   //////////////////////////////////////////////////////////////////////
   assign miso = slave_shift[7];

   always @(negedge clk) begin
      if (prev_sck && !sd.sck) slave_shift = {slave_shift[6:0], 1'b1};
      if (sd.sck) begin
         mosi_seen = {mosi_seen[6:0], sd.mosi};  // One clk per high phase
         sck_pulses++;
      end
      prev_sck = sd.sck;
   end

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic check_mem(input divmmc_pkg::mem_sel_t got,
                            input divmmc_pkg::mem_sel_t exp, input string name);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string name);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string name);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   function automatic divmmc_pkg::mem_sel_t make_sel(input logic ee_cs_n, input logic ee_we_n,
         input logic sr_cs_n, input logic sr_we_n, input logic [5:0] hiaddr);
      divmmc_pkg::mem_sel_t s;
      s.eeprom_cs_n = ee_cs_n;
      s.eeprom_we_n = ee_we_n;
      s.sram_cs_n   = sr_cs_n;
      s.sram_we_n   = sr_we_n;
      s.sram_hiaddr = hiaddr;
      return s;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // CPU bus cycles, all start and end on a falling edge
   //////////////////////////////////////////////////////////////////////
   task automatic drive_idle();
      bus.a      = 16'h0000;
      bus.mreq_n = 1'b1;
      bus.iorq_n = 1'b1;
      bus.rd_n   = 1'b1;
      bus.wr_n   = 1'b1;
      bus.m1_n   = 1'b1;
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] data);
      bus.a      = {8'h00, port};
      bus.iorq_n = 1'b0;
      bus.wr_n   = 1'b0;
      d_in       = data;
      repeat (2) @(negedge clk);
      drive_idle();
   endtask

   task automatic mem_cycle(input logic [15:0] addr, input logic write,
                            input divmmc_pkg::mem_sel_t exp);
      bus.a      = addr;
      bus.mreq_n = 1'b0;
      if (write) bus.wr_n = 1'b0;
      else bus.rd_n = 1'b0;
      #1;  // Selects are combinational
      check_mem(mem, exp, "mem");
      @(negedge clk);
      drive_idle();
   endtask

   // zxromcs late in the M1 phase and one clk after it
   task automatic m1_fetch(input logic [15:0] addr, output logic during, output logic after);
      bus.a      = addr;
      bus.mreq_n = 1'b0;
      bus.rd_n   = 1'b0;
      bus.m1_n   = 1'b0;
      repeat (2) @(negedge clk);
      during = zxromcs;
      drive_idle();
      @(negedge clk);
      after = zxromcs;
   endtask

   task automatic load_slave(input logic [7:0] data);
      slave_shift = data;  // First bit out at transfer start
      mosi_seen   = 8'h00;
      sck_pulses  = 0;
   endtask

   task automatic spi_write(input logic [7:0] data, input logic [7:0] card_byte);
      load_slave(card_byte);
      bus.a      = {8'h00, divmmc_pkg::spi_port};
      bus.iorq_n = 1'b0;
      bus.wr_n   = 1'b0;
      d_in       = data;
      repeat (19) @(negedge clk);  // 16 clk transfer plus start
      drive_idle();
      @(negedge clk);
      check_byte(8'(sck_pulses), 8'd8, "sck pulses");
      check_byte(mosi_seen, data, "mosi");
      check_bit(sd.sck, 1'b0, "sck");
   endtask

   task automatic spi_read(input logic [7:0] exp, input logic [7:0] card_byte);
      load_slave(card_byte);
      bus.a      = {8'h00, divmmc_pkg::spi_port};
      bus.iorq_n = 1'b0;
      bus.rd_n   = 1'b0;
      #1;  // Byte already on the bus before the first edge
      check_byte(d_out, exp, "d_out");
      check_bit(d_oe, 1'b1, "d_oe");
      @(negedge clk);
      check_byte(d_out, exp, "d_out");
      check_bit(d_oe, 1'b1, "d_oe");
      repeat (18) @(negedge clk);
      drive_idle();
      @(negedge clk);
      check_byte(8'(sck_pulses), 8'd8, "sck pulses");
      check_byte(mosi_seen, 8'hFF, "mosi");
      check_bit(d_oe, 1'b0, "d_oe");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////
   task automatic test_reset_state();
      check_mem(mem, make_sel(1, 1, 1, 1, 6'h00), "mem");
      check_bit(zxromcs, 1'b0, "zxromcs");
      check_bit(nmi_to_cpu_n, 1'b1, "nmi_to_cpu_n");
      check_bit(sd.ss_n, 1'b1, "ss_n");
      check_bit(sd.sck, 1'b0, "sck");
      check_bit(sd.mosi, 1'b1, "mosi");
      check_bit(d_oe, 1'b0, "d_oe");
   endtask

   task automatic test_conmem();
      io_write(divmmc_pkg::ctrl_port, 8'hC5);  // conmem, mapram, page 5
      check_bit(zxromcs, 1'b1, "zxromcs");
      mem_cycle(16'h1000, 1'b0, make_sel(0, 1, 1, 1, 6'h05));
      mem_cycle(16'h2100, 1'b1, make_sel(1, 1, 0, 0, 6'h05));
      io_write(divmmc_pkg::ctrl_port, 8'h00);
      check_bit(zxromcs, 1'b0, "zxromcs");
      mem_cycle(16'h1000, 1'b0, make_sel(1, 1, 1, 1, 6'h00));
   endtask

   task automatic test_automap();
      logic during;
      logic after;
      nmi_button_n = 1'b0;
      @(negedge clk);
      check_bit(nmi_to_cpu_n, 1'b0, "nmi_to_cpu_n");  // Unpaged, NMI passes
      nmi_button_n = 1'b1;
      m1_fetch(16'h0038, during, after);  // Deferred entry
      check_bit(during, 1'b0, "zxromcs");
      check_bit(after, 1'b1, "zxromcs");
      nmi_button_n = 1'b0;
      @(negedge clk);
      check_bit(nmi_to_cpu_n, 1'b1, "nmi_to_cpu_n");  // Paged, NMI blocked
      nmi_button_n = 1'b1;
      m1_fetch(16'h1FF8, during, after);  // Exit window
      check_bit(during, 1'b1, "zxromcs");
      check_bit(after, 1'b0, "zxromcs");
      m1_fetch(16'h3D10, during, after);  // Immediate page-in
      check_bit(during, 1'b1, "zxromcs");
      check_bit(after, 1'b1, "zxromcs");
   endtask

   // Runs while paged from the 3Dxx fetch
   task automatic test_mapram();
      logic during;
      logic after;
      io_write(divmmc_pkg::ctrl_port, 8'h43);
      mem_cycle(16'h0500, 1'b0, make_sel(1, 1, 0, 1, 6'h03));
      mem_cycle(16'h2000, 1'b1, make_sel(1, 1, 0, 1, 6'h03));  // Page 3 protected
      io_write(divmmc_pkg::ctrl_port, 8'h44);
      mem_cycle(16'h2000, 1'b1, make_sel(1, 1, 0, 0, 6'h04));
      io_write(divmmc_pkg::ctrl_port, 8'h00);
      m1_fetch(16'h1FFF, during, after);
      check_bit(during, 1'b1, "zxromcs");
      check_bit(after, 1'b0, "zxromcs");
   endtask

   task automatic test_program();
      logic during;
      logic after;
      program_n = 1'b0;
      m1_fetch(16'h0000, during, after);  // Automap off
      check_bit(during, 1'b0, "zxromcs");
      check_bit(after, 1'b0, "zxromcs");
      io_write(divmmc_pkg::ctrl_port, 8'h80);
      mem_cycle(16'h0100, 1'b1, make_sel(0, 0, 1, 1, 6'h00));
      io_write(divmmc_pkg::ctrl_port, 8'h00);
      program_n = 1'b1;
   endtask

   task automatic test_sd();
      io_write(divmmc_pkg::cs_port, 8'h00);
      check_bit(sd.ss_n, 1'b0, "ss_n");
      spi_write(8'hA6, 8'h3C);
      spi_read(8'h3C, 8'h81);  // Byte of the write transfer
      spi_read(8'h81, 8'hFF);
      io_write(divmmc_pkg::cs_port, 8'h01);
      check_bit(sd.ss_n, 1'b1, "ss_n");
   endtask

   initial begin
      rst_n        = 1'b0;
      program_n    = 1'b1;
      nmi_button_n = 1'b1;
      d_in         = 8'h00;
      drive_idle();
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      test_reset_state();
      test_conmem();
      test_automap();
      test_mapram();
      test_program();
      test_sd();
      repeat (2) @(negedge clk);
      $display("Summary: %0d check errors, %0d assertion failures", errors,
               divmmc_inst.asserts_inst.assert_errors);
      if (errors == 0 && divmmc_inst.asserts_inst.assert_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- tests/divmmc_asserts.sv
module divmmc_asserts (
   input logic                  clk,
   input logic                  rst_n,
   input divmmc_pkg::z80_bus_t  bus,
   input logic [7:0]            d_in,
   input divmmc_pkg::mem_sel_t  mem,
   input divmmc_pkg::spi_pins_t sd,
   input logic                  d_oe,
   input logic                  zxromcs,
   input logic                  paged
);
   timeunit 1ns;
   timeprecision 100ps;

   int   assert_errors = 0;  // Count of failed assertions
   logic conmem;             // Bit 7 of the last write to E3

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         conmem <= 1'b0;
      end else if (!bus.iorq_n && !bus.wr_n && (bus.a[7:0] == divmmc_pkg::ctrl_port)) begin
         conmem <= d_in[7];
      end
   end

   // One memory chip at a time on the shared data bus
   one_chip_sel: assert property (@(posedge clk) disable iff (!rst_n)
      !(!mem.eeprom_cs_n && !mem.sram_cs_n))
      else begin
         assert_errors++;
         $error("EEPROM and SRAM selected together");
      end

   doe_only_spi_read: assert property (@(posedge clk) disable iff (!rst_n)
      d_oe |-> (!bus.iorq_n && !bus.rd_n && (bus.a[7:0] == divmmc_pkg::spi_port)))
      else begin
         assert_errors++;
         $error("Data bus driven outside a read of the SPI port");
      end

   // Card deselected and clock idle right after reset
   sck_low_after_reset: assert property (@(posedge clk)
      !rst_n |=> (sd.ss_n && !sd.sck))
      else begin
         assert_errors++;
         $error("SD clock not idle after reset");
      end

   romcs_only_mapped: assert property (@(posedge clk) disable iff (!rst_n)
      zxromcs |-> (paged || conmem))
      else begin
         assert_errors++;
         $error("Host ROM disabled while unmapped");
      end

endmodule

bind divmmc divmmc_asserts asserts_inst (
   .clk     (clk),
   .rst_n   (rst_n),
   .bus     (bus),
   .d_in    (d_in),
   .mem     (mem),
   .sd      (sd),
   .d_oe    (d_oe),
   .zxromcs (zxromcs),
   .paged   (paged)
);

//--- src/divmmc.sv
module divmmc (
   input  logic                  clk,
   input  logic                  rst_n,
   // CPU bus
   input  divmmc_pkg::z80_bus_t  bus,
   input  logic [7:0]            d_in,
   output logic [7:0]            d_out,
   output logic                  d_oe,
   // Jumper and NMI
   input  logic                  program_n,
   input  logic                  nmi_button_n,
   output logic                  nmi_to_cpu_n,  // Open drain on the board
   // Memories and host ROM
   output logic                  zxromcs,
   output divmmc_pkg::mem_sel_t  mem,
   // SD card
   input  logic                  miso,
   output divmmc_pkg::spi_pins_t sd
);

   logic paged;  // Automapper state, feeds the memory decode

   divmmc_automap automap_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .bus          (bus),
      .program_n    (program_n),
      .nmi_button_n (nmi_button_n),
      .paged        (paged),
      .nmi_to_cpu_n (nmi_to_cpu_n)
   );

   divmmc_mem_map mem_map_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .bus       (bus),
      .d_in      (d_in),
      .program_n (program_n),
      .paged     (paged),
      .mem       (mem),
      .zxromcs   (zxromcs)
   );

   divmmc_sd_port sd_port_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (bus),
      .d_in  (d_in),
      .miso  (miso),
      .sd    (sd),
      .d_out (d_out),
      .d_oe  (d_oe)
   );

endmodule

//--- src/divmmc_sd_port.sv
module divmmc_sd_port (
   input  logic                  clk,
   input  logic                  rst_n,
   input  divmmc_pkg::z80_bus_t  bus,
   input  logic [7:0]            d_in,
   input  logic                  miso,
   output divmmc_pkg::spi_pins_t sd,
   output logic [7:0]            d_out,
   output logic                  d_oe
);

   logic cs_bit;       // Card deselected after reset
   logic cs_wr;
   logic start_write;
   logic start_read;
   logic spi_sck;
   logic spi_mosi;

   //////////////////////////////////////////////////////////////////////
   // Port decode
   //////////////////////////////////////////////////////////////////////
   assign cs_wr       = !bus.iorq_n && !bus.wr_n && (bus.a[7:0] == divmmc_pkg::cs_port);
   assign start_write = !bus.iorq_n && !bus.wr_n && (bus.a[7:0] == divmmc_pkg::spi_port);
   assign start_read  = !bus.iorq_n && !bus.rd_n && (bus.a[7:0] == divmmc_pkg::spi_port);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cs_bit <= 1'b1;
      end else if (cs_wr) begin
         cs_bit <= d_in[0];  // Bit 0 only, card 0
      end
   end

   divmmc_spi spi_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .start_write (start_write),
      .start_read  (start_read),
      .d_in        (d_in),
      .miso        (miso),
      .sck         (spi_sck),
      .mosi        (spi_mosi),
      .rx_byte     (d_out)
   );

   assign sd.ss_n = cs_bit;
   assign sd.sck  = spi_sck;
   assign sd.mosi = spi_mosi;

   assign d_oe = start_read;  // Drive the data bus only during the read

endmodule

//--- src/divmmc_spi.sv
module divmmc_spi (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       start_write,  // Held while the port write lasts
   input  logic       start_read,   // Held while the port read lasts
   input  logic [7:0] d_in,
   input  logic       miso,
   output logic       sck,
   output logic       mosi,
   output logic [7:0] rx_byte       // Byte returned to the CPU
);

   logic       write_cycle;
   logic       read_cycle;
   logic [4:0] count;     // Half-bit counter
   logic [7:0] tx_shift;
   logic [7:0] rx_shift;
   logic [7:0] rx_latch;  // Previous transfer, taken at read start
   logic       write_go;
   logic       read_go;
   logic       done;

   assign write_go = start_write && !write_cycle;
   assign read_go  = start_read && !read_cycle;
   assign done     = (count == divmmc_pkg::spi_count_end);

   assign sck  = count[0];     // Half the module clock
   assign mosi = tx_shift[7];  // MSB first

   //////////////////////////////////////////////////////////////////////
   // Shift engine
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         write_cycle <= 1'b0;
         read_cycle  <= 1'b0;
         count       <= '0;
         tx_shift    <= 8'hFF;  // Line idles high
         rx_shift    <= '0;
         rx_latch    <= '0;
      end else if (write_go) begin
         write_cycle <= 1'b1;
         read_cycle  <= 1'b0;
         count       <= '0;
         tx_shift    <= d_in;
      end else if (read_go) begin
         read_cycle  <= 1'b1;
         write_cycle <= 1'b0;
         count       <= '0;
         rx_latch    <= rx_shift;  // Result of the last transfer
         rx_shift    <= '0;
         tx_shift    <= 8'hFF;     // Card sees all ones during a read
      end else if (write_cycle || read_cycle) begin
         if (!done) begin
            // End of the high phase, sample and move on
            if (sck) begin
               tx_shift <= {tx_shift[6:0], 1'b1};
               rx_shift <= {rx_shift[6:0], miso};
            end
            count <= count + 5'd1;
         end else begin
            // Idle until the CPU releases the strobe
            if (write_cycle && !start_write) begin
               write_cycle <= 1'b0;
            end
            if (read_cycle && !start_read) begin
               read_cycle <= 1'b0;
            end
         end
      end
   end

   // Bypass so the byte is already valid in the first cycle of the read
   assign rx_byte = read_go ? rx_shift : rx_latch;

endmodule

//--- src/divmmc_mem_map.sv
module divmmc_mem_map (
   input  logic                 clk,
   input  logic                 rst_n,
   input  divmmc_pkg::z80_bus_t bus,
   input  logic [7:0]           d_in,
   input  logic                 program_n,  // Low allows EEPROM writes
   input  logic                 paged,
   output divmmc_pkg::mem_sel_t mem,
   output logic                 zxromcs     // High disables the host ROM
);

   divmmc_pkg::divmmc_ctrl_t ctrl;
   logic ctrl_wr;
   logic mapped;
   logic mapram_act;  // MAPRAM in effect, not overridden by conmem

   //////////////////////////////////////////////////////////////////////
   // Control register at E3
   //////////////////////////////////////////////////////////////////////
   assign ctrl_wr = !bus.iorq_n && !bus.wr_n && (bus.a[7:0] == divmmc_pkg::ctrl_port);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl <= '0;
      end else if (ctrl_wr) begin
         ctrl <= d_in;
      end
   end

   assign mapped     = paged || ctrl.conmem;
   assign mapram_act = ctrl.mapram && !ctrl.conmem;
   assign zxromcs    = mapped;

   //////////////////////////////////////////////////////////////////////
   // EEPROM and SRAM selects
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      mem.eeprom_cs_n = 1'b1;
      mem.eeprom_we_n = 1'b1;
      mem.sram_cs_n   = 1'b1;
      mem.sram_we_n   = 1'b1;
      mem.sram_hiaddr = ctrl.page;  // Default bank
      if (!bus.mreq_n && mapped) begin
         if (bus.a[15:13] == 3'b000) begin
            // 0000-1FFF, EEPROM or SRAM page 3
            if (!mapram_act) begin
               mem.eeprom_cs_n = 1'b0;
               mem.eeprom_we_n = bus.wr_n || program_n;  // Only while programming
            end else begin
               mem.sram_cs_n   = 1'b0;
               mem.sram_hiaddr = divmmc_pkg::mapram_page;  // Read-only here
            end
         end else if (bus.a[15:13] == 3'b001) begin
            // 2000-3FFF, switchable SRAM bank
            mem.sram_cs_n = 1'b0;
            if (!mapram_act || (ctrl.page != divmmc_pkg::mapram_page)) begin
               mem.sram_we_n = bus.wr_n;
            end
         end
      end
   end

endmodule

//--- src/divmmc_automap.sv
module divmmc_automap (
   input  logic                 clk,
   input  logic                 rst_n,
   input  divmmc_pkg::z80_bus_t bus,
   input  logic                 program_n,     // Low disables automapping
   input  logic                 nmi_button_n,  // Button pulls to ground
   output logic                 paged,
   output logic                 nmi_to_cpu_n
);

   logic pending;     // Paging state to take effect after M1
   logic m1_fetch;    // Opcode fetch seen while automap allowed
   logic entry_hit;
   logic rom3_hit;
   logic exit_hit;

   // Opcode fetch is the only cycle that triggers paging
   assign m1_fetch = program_n && !bus.mreq_n && !bus.rd_n && !bus.m1_n;

   assign entry_hit = (bus.a == divmmc_pkg::automap_entry_0) ||
                      (bus.a == divmmc_pkg::automap_entry_1) ||
                      (bus.a == divmmc_pkg::automap_entry_2) ||
                      (bus.a == divmmc_pkg::automap_entry_3) ||
                      (bus.a == divmmc_pkg::automap_entry_4) ||
                      (bus.a == divmmc_pkg::automap_entry_5);

   assign rom3_hit = (bus.a[15:8] == divmmc_pkg::automap_rom3_hi);
   assign exit_hit = (bus.a[15:3] == divmmc_pkg::automap_exit_base);

   //////////////////////////////////////////////////////////////////////
   // Pending flag and paged level
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending <= 1'b0;
         paged   <= 1'b0;
      end else begin
         if (m1_fetch && entry_hit) begin
            pending <= 1'b1;  // Deferred page-in
         end else if (m1_fetch && rom3_hit) begin
            pending <= 1'b1;
            paged   <= 1'b1;  // Immediate, during this fetch
         end else if (m1_fetch && exit_hit) begin
            pending <= 1'b0;  // Deferred page-out
         end
         // After the M1 phase the pending state takes over, also over a 3Dxx hit
         if (bus.m1_n) begin
            paged <= pending;
         end
      end
   end

   // NMI only reaches the CPU while unpaged, which stops the button re-entering
   assign nmi_to_cpu_n = nmi_button_n || paged;

endmodule

//--- src/divmmc_pkg.sv
package divmmc_pkg;

   //////////////////////////////////////////////////////////////////////
   // I/O ports, low address byte only
   //////////////////////////////////////////////////////////////////////
   localparam logic [7:0] ctrl_port = 8'hE3;  // Control register
   localparam logic [7:0] cs_port   = 8'hE7;  // SD card chip select
   localparam logic [7:0] spi_port  = 8'hEB;  // SPI data

   // Deferred entry points, paged in after the M1 phase
   localparam logic [15:0] automap_entry_0 = 16'h0000;  // Reset
   localparam logic [15:0] automap_entry_1 = 16'h0008;  // RST 8, error handler
   localparam logic [15:0] automap_entry_2 = 16'h0038;  // IM1 interrupt
   localparam logic [15:0] automap_entry_3 = 16'h0066;  // NMI
   localparam logic [15:0] automap_entry_4 = 16'h04C6;  // Tape save
   localparam logic [15:0] automap_entry_5 = 16'h0562;  // Tape load

   localparam logic [7:0]  automap_rom3_hi   = 8'h3D;            // Immediate page-in
   localparam logic [12:0] automap_exit_base = 13'b0001111111111; // 1FF8-1FFF

   localparam logic [5:0] mapram_page = 6'd3;  // Write-protected in MAPRAM mode

   // Half-bit counter end, 8 bits of two phases each
   localparam logic [4:0] spi_count_end = 5'd16;

   //////////////////////////////////////////////////////////////////////
   // Bus and register types
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [15:0] a;
      logic        mreq_n;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
      logic        m1_n;
   } z80_bus_t;

   typedef struct packed {
      logic       conmem;  // Force mapping
      logic       mapram;  // SRAM page 3 replaces the EEPROM
      logic [5:0] page;    // SRAM bank at 2000-3FFF
   } divmmc_ctrl_t;

   typedef struct packed {
      logic       eeprom_cs_n;
      logic       eeprom_we_n;
      logic       sram_cs_n;
      logic       sram_we_n;
      logic [5:0] sram_hiaddr;
   } mem_sel_t;

   typedef struct packed {
      logic ss_n;
      logic sck;
      logic mosi;
   } spi_pins_t;

endpackage
